// File: ntm_vector_product_top.f
hdl/ntm_arith_pkg.sv
hdl/ntm_ctrl_pkg.sv
hdl/ntm_modular_multiplier.sv
hdl/ntm_scalar_product.sv
hdl/ntm_vector_product.sv
hdl/ntm_vector_product_top.sv
testbench/ntm_vector_product_tb.sv

// File: testbench/ntm_vector_product_tb.sv
// INDEX_SIZE 8 and 16-bit words; operands stay below the modulus and only one is in flight
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product_tb
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int INDEX_SIZE      = 8;
  // Enable to scalar_valid latency in falling edges
  localparam int LATENCY         = DATA_SIZE + 3;
  // Operands over all runs below
  localparam int TOTAL_OPS       = 34;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 25 + 300;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic [INDEX_SIZE-1:0] size;
  logic [INDEX_SIZE-1:0] length;
  ntm_data_t             modulo;
  logic                  data_in_vector_enable;
  logic                  data_in_scalar_enable;
  ntm_data_t             data_in;
  ntm_data_t             data_out;
  ntm_out_flags_t        flags;

  // Expected results in issue order
  ntm_data_t             exp_data_q[$];
  ntm_out_flags_t        exp_flags_q[$];
  ntm_data_t             ops[$];
  logic [31:0]           rng_state   = 32'hec2c;
  int                    ready_count = 0;
  int                    vectors_run = 0;

  ntm_vector_product_top #(
    .INDEX_SIZE (INDEX_SIZE)
  ) dut0 (
    .CLK                   (CLK),
    .RST                   (RST),
    .start                 (start),
    .size                  (size),
    .length                (length),
    .modulo                (modulo),
    .data_in_vector_enable (data_in_vector_enable),
    .data_in_scalar_enable (data_in_scalar_enable),
    .data_in               (data_in),
    .data_out              (data_out),
    .flags                 (flags)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model, random source and checks
  ////////////////////////////////////////////////////////////////////////////

  // Next running product in 64 bits so nothing wraps
  function automatic ntm_data_t ref_mod_product(input ntm_data_t running, input ntm_data_t value,
                                                input ntm_data_t m);
    logic [63:0] wide;
    wide = 64'(running) * 64'(value);
    return ntm_data_t'(wide % 64'(m));
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_below(input logic [31:0] bound, output ntm_data_t value);
    rng_state = xorshift32(rng_state);
    value     = ntm_data_t'(rng_state % bound);
  endtask

  // Modulus in 2 .. 0xFFFF
  task automatic draw_modulus(output ntm_data_t m);
    ntm_data_t r;
    draw_below(32'hfffe, r);
    m = r + 16'd2;
  endtask

  task automatic fill_random_ops(input ntm_data_t m, input int count);
    ntm_data_t v;
    ops.delete();
    repeat (count) begin
      draw_below(32'(m), v);
      ops.push_back(v);
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input ntm_data_t exp, input ntm_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED at %0t ns: %s expected 0x%h, got 0x%h",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_flags(input string name, input ntm_out_flags_t exp,
                             input ntm_out_flags_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED at %0t ns: %s expected %b, got %b (ready,end,valid)",
                              $time, name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host side stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Sends one operand and counts falling edges until its scalar_valid
  task automatic send_operand(input logic first, input ntm_data_t value, output int latency);
    ntm_vector_state_e st;
    logic              seen;
    @(negedge CLK);
    data_in               = value;
    data_in_vector_enable = first;
    data_in_scalar_enable = !first;
    latency = 0;
    seen    = 1'b0;
    while (!seen) begin
      @(negedge CLK);
      data_in_vector_enable = 1'b0;
      data_in_scalar_enable = 1'b0;
      latency++;
      seen = (flags.scalar_valid === 1'b1);
      if (!seen && latency > 2 * LATENCY) begin
        st = dut0.u_vector.state;
        stop_on_error($sformatf("No scalar_valid within %0d cycles of operand 0x%h, state %s",
                                latency, value, st.name()));
      end
    end
  endtask

  // Enable the sequencer does not expect so the junk data never reaches a result
  task automatic pulse_stray_scalar(input ntm_data_t junk);
    @(negedge CLK);
    data_in               = junk;
    data_in_scalar_enable = 1'b1;
    @(negedge CLK);
    data_in_scalar_enable = 1'b0;
  endtask

  // Start with a different config while a run is active
  task automatic pulse_late_start();
    @(negedge CLK);
    start  = 1'b1;
    size   = INDEX_SIZE'(1);
    length = INDEX_SIZE'(1);
    modulo = 16'h0003;
    @(negedge CLK);
    start  = 1'b0;
  endtask

  // Whole vector from ops with expected results queued before each operand
  task automatic run_vector(input ntm_data_t m, input int n_size, input int n_len,
                            input logic inject);
    ntm_data_t      running;
    ntm_data_t      value;
    ntm_out_flags_t exp_flags;
    int             idx;
    int             lat;
    if (ops.size() != n_size * n_len) stop_on_error("Operand list does not fit size and length");
    @(negedge CLK);
    start  = 1'b1;
    size   = INDEX_SIZE'(n_size);
    length = INDEX_SIZE'(n_len);
    modulo = m;
    @(negedge CLK);
    start  = 1'b0;
    if (inject) pulse_stray_scalar(16'hbeef);
    idx = 0;
    for (int e = 0; e < n_size; e++) begin
      // Each element starts over from 1
      running = ntm_data_t'(1);
      for (int k = 0; k < n_len; k++) begin
        value   = ops[idx];
        idx++;
        running = ref_mod_product(running, value, m);
        exp_flags.scalar_valid = 1'b1;
        exp_flags.vector_end   = (k == n_len - 1);
        exp_flags.ready        = (k == n_len - 1) && (e == n_size - 1);
        exp_data_q.push_back(running);
        exp_flags_q.push_back(exp_flags);
        send_operand(k == 0, value, lat);
        if (lat != LATENCY) begin
          stop_on_error($sformatf("FAILED at %0t ns: scalar_valid latency expected %0d, got %0d",
                                  $time, LATENCY, lat));
        end
        // Skipped after the last result because the engine is idle then
        if (inject && !exp_flags.ready) begin
          if (e == 0 && k == 0) pulse_late_start();
          if (exp_flags.vector_end) pulse_stray_scalar(16'h5a5a);
        end
      end
    end
    vectors_run++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ntm_data_t      exp_data;
    ntm_out_flags_t exp_flags;
    forever begin
      @(negedge CLK);
      if (!RST && flags !== '0) begin
        if (exp_data_q.size() == 0) begin
          stop_on_error($sformatf("Flag pulse %b at %0t ns with no result pending",
                                  flags, $time));
        end else begin
          exp_data  = exp_data_q.pop_front();
          exp_flags = exp_flags_q.pop_front();
          check_flags("flags", exp_flags, flags);
          check_data("data_out", exp_data, data_out);
          if (flags.ready) ready_count++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("Watchdog expired after %0d cycles before the run finished",
                            WATCHDOG_CYCLES));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ntm_data_t m;
    RST                   = 1'b1;
    start                 = 1'b0;
    size                  = '0;
    length                = '0;
    modulo                = '0;
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
    data_in               = '0;
    repeat (8) @(negedge CLK);
    RST = 1'b0;

    // Quiet outputs after reset
    repeat (3) begin
      @(negedge CLK);
      check_flags("flags", ntm_out_flags_t'('0), flags);
      check_data("data_out", ntm_data_t'('0), data_out);
    end

    // Single operand with all strobes at once
    draw_modulus(m);
    fill_random_ops(m, 1);
    run_vector(m, 1, 1, 1'b0);

    // One element of five
    draw_modulus(m);
    fill_random_ops(m, 5);
    run_vector(m, 1, 5, 1'b0);

    // Four elements of three with a restart per element
    draw_modulus(m);
    fill_random_ops(m, 12);
    run_vector(m, 4, 3, 1'b0);

    // Late start and stray scalar enables
    draw_modulus(m);
    fill_random_ops(m, 6);
    run_vector(m, 2, 3, 1'b1);

    // Edge moduli with operands 0 and m-1
    ops = '{16'h0001, 16'h0001, 16'h0000, 16'h0001};
    run_vector(16'h0002, 1, 4, 1'b0);
    ops = '{16'hfffe, 16'hfffe, 16'hfffe, 16'h0000, 16'hfffe, 16'h0001};
    run_vector(16'hffff, 2, 3, 1'b0);

    repeat (5) @(negedge CLK);
    if (exp_data_q.size() != 0 || ready_count != vectors_run) begin
      stop_on_error($sformatf("Run ended with %0d results missing and %0d ready for %0d vectors",
                              exp_data_q.size(), ready_count, vectors_run));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ntm_vector_product_top.sv
// Top wrapper without a bus interface; data_out and flags follow a data_in enable by 19 cycles
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product_top
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
#(
  // Width of size, length and loop counters
  parameter int INDEX_SIZE = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size,
  input  logic [INDEX_SIZE-1:0] length,
  input  ntm_data_t             modulo,
  input  logic                  data_in_vector_enable,
  input  logic                  data_in_scalar_enable,
  input  ntm_data_t             data_in,
  output ntm_data_t             data_out,
  output ntm_out_flags_t        flags
);

  // Vector sequencer with its scalar unit and multiplier below
  ntm_vector_product #(
    .INDEX_SIZE (INDEX_SIZE)
  ) u_vector (
    .CLK                   (CLK),
    .RST                   (RST),
    .start                 (start),
    .size                  (size),
    .length                (length),
    .modulo                (modulo),
    .data_in_vector_enable (data_in_vector_enable),
    .data_in_scalar_enable (data_in_scalar_enable),
    .data_in               (data_in),
    .data_out              (data_out),
    .flags                 (flags)
  );

endmodule

`default_nettype wire

// File: hdl/ntm_vector_product.sv
// Size and length must be >= 1; without back-pressure the next operand waits for scalar_valid
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_product
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
#(
  parameter int INDEX_SIZE = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size,
  input  logic [INDEX_SIZE-1:0] length,
  input  ntm_data_t             modulo,
  input  logic                  data_in_vector_enable,
  input  logic                  data_in_scalar_enable,
  input  ntm_data_t             data_in,
  output ntm_data_t             data_out,
  output ntm_out_flags_t        flags
);

  ntm_vector_state_e     state;

  // Configuration latched on start
  logic [INDEX_SIZE-1:0] size_q;
  logic [INDEX_SIZE-1:0] length_q;
  ntm_data_t             modulo_q;

  // Loop counters
  logic [INDEX_SIZE-1:0] elem_cnt;
  logic [INDEX_SIZE-1:0] op_cnt;
  logic                  last_operand;
  logic                  last_element;

  // Scalar unit interface
  logic                  accept_vector;
  logic                  accept_scalar;
  logic                  restart;
  logic                  operand_valid;
  ntm_operand_t          operand;
  ntm_data_t             product;
  logic                  product_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Operand acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Only the enable the counters call for is taken
  assign accept_vector = (state == VECTOR_WAIT_VECTOR) && data_in_vector_enable;
  assign accept_scalar = (state == VECTOR_WAIT_SCALAR) && data_in_scalar_enable;
  assign operand_valid = accept_vector || accept_scalar;
  // First operand of an element resets the running product
  assign restart       = accept_vector;

  always_comb begin
    operand.modulo = modulo_q;
    operand.data   = data_in;
  end

  assign last_operand = (op_cnt == length_q - 1'b1);
  assign last_element = (elem_cnt == size_q - 1'b1);

  ntm_scalar_product u_scalar (
    .CLK           (CLK),
    .RST           (RST),
    .restart       (restart),
    .operand_valid (operand_valid),
    .operand       (operand),
    .product       (product),
    .product_valid (product_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Loop control and output strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= VECTOR_IDLE;
      size_q   <= '0;
      length_q <= '0;
      modulo_q <= '0;
      elem_cnt <= '0;
      op_cnt   <= '0;
      data_out <= '0;
      flags    <= '0;
    end else begin
      // Strobes last one cycle
      flags <= '0;
      case (state)
        VECTOR_IDLE: begin
          if (start) begin
            size_q   <= size;
            length_q <= length;
            modulo_q <= modulo;
            elem_cnt <= '0;
            op_cnt   <= '0;
            state    <= VECTOR_WAIT_VECTOR;
          end
        end
        VECTOR_WAIT_VECTOR: if (accept_vector) state <= VECTOR_BUSY;
        VECTOR_WAIT_SCALAR: if (accept_scalar) state <= VECTOR_BUSY;
        VECTOR_BUSY: begin
          if (product_valid) begin
            data_out           <= product;
            flags.scalar_valid <= 1'b1;
            if (last_operand) begin
              // Element done
              flags.vector_end <= 1'b1;
              op_cnt           <= '0;
              if (last_element) begin
                flags.ready <= 1'b1;
                state       <= VECTOR_IDLE;
              end else begin
                elem_cnt <= elem_cnt + 1'b1;
                state    <= VECTOR_WAIT_VECTOR;
              end
            end else begin
              op_cnt <= op_cnt + 1'b1;
              state  <= VECTOR_WAIT_SCALAR;
            end
          end
        end
        default: state <= VECTOR_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_config_nonzero: assert property (@(posedge CLK) disable iff (RST)
    (start && state == VECTOR_IDLE) |-> (size != '0 && length != '0))
    else $error("start with zero size or length");

  a_no_enable_busy: assert property (@(posedge CLK) disable iff (RST)
    (state == VECTOR_BUSY) |-> !(data_in_vector_enable || data_in_scalar_enable))
    else $error("operand enable while a product is in flight");

endmodule

`default_nettype wire

// File: hdl/ntm_scalar_product.sv
// Without back-pressure operand_valid may come only while idle; product_valid follows 18 cycles later
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_product
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         restart,
  input  logic         operand_valid,
  input  ntm_operand_t operand,
  output ntm_data_t    product,
  output logic         product_valid
);

  ntm_scalar_state_e state;

  // Registered operand and running product
  ntm_operand_t      op_q;
  ntm_data_t         running;

  // Multiplier handshake
  logic              mul_start;
  ntm_data_t         mul_result;
  logic              mul_done;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  // idle -> load (one cycle) -> multiply until done
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SCALAR_IDLE;
    end else begin
      case (state)
        SCALAR_IDLE:     if (operand_valid) state <= SCALAR_LOAD;
        SCALAR_LOAD:     state <= SCALAR_MULTIPLY;
        SCALAR_MULTIPLY: if (mul_done) state <= SCALAR_IDLE;
        default:         state <= SCALAR_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == SCALAR_IDLE && operand_valid) begin
      op_q <= operand;
      // New element starts from the neutral element
      if (restart) running <= ntm_data_t'(1);
    end
    // Write back for the next operand
    if (state == SCALAR_MULTIPLY && mul_done) running <= mul_result;
  end

  // Running product is already updated when load is reached
  assign mul_start = (state == SCALAR_LOAD);

  ntm_modular_multiplier u_multiplier (
    .CLK          (CLK),
    .RST          (RST),
    .mul_start    (mul_start),
    .operand      (op_q),
    .multiplicand (running),
    .result       (mul_result),
    .done         (mul_done)
  );

  // Result goes out in the done cycle
  assign product       = mul_result;
  assign product_valid = (state == SCALAR_MULTIPLY) && mul_done;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_no_overlap: assert property (@(posedge CLK) disable iff (RST)
    operand_valid |-> state == SCALAR_IDLE)
    else $error("operand_valid during a multiply");

endmodule

`default_nettype wire

// File: hdl/ntm_modular_multiplier.sv
// Needs operand.data below operand.modulo and modulo >= 2; done pulses 17 cycles after mul_start
`timescale 1ns/1ps
`default_nettype none

module ntm_modular_multiplier
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         mul_start,
  input  ntm_operand_t operand,
  input  ntm_data_t    multiplicand,
  output ntm_data_t    result,
  output logic         done
);

  // Bit counter width
  localparam int CNT_W = $clog2(DATA_SIZE);

  ntm_scalar_state_e state;
  logic [CNT_W-1:0]  bit_cnt;

  // Latched operands and partial result
  ntm_operand_t      op_q;
  ntm_data_t         mult_q;
  ntm_data_t         acc;

  // One extra bit for 2*acc and acc+a before reduction
  logic [DATA_SIZE:0] dbl;
  logic [DATA_SIZE:0] dbl_red;
  logic [DATA_SIZE:0] sum;
  logic [DATA_SIZE:0] sum_red;

  ////////////////////////////////////////////////////////////////////////////
  // One shift-add step from the MSB down
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Double, then pull back below the modulus
    dbl     = {acc, 1'b0};
    dbl_red = (dbl >= {1'b0, op_q.modulo}) ? dbl - {1'b0, op_q.modulo} : dbl;
    // Add a when the current multiplicand bit is set
    sum     = dbl_red + (mult_q[bit_cnt] ? {1'b0, op_q.data} : '0);
    sum_red = (sum >= {1'b0, op_q.modulo}) ? sum - {1'b0, op_q.modulo} : sum;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= SCALAR_IDLE;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SCALAR_IDLE: begin
          if (mul_start) begin
            bit_cnt <= CNT_W'(DATA_SIZE - 1);
            state   <= SCALAR_MULTIPLY;
          end
        end
        SCALAR_MULTIPLY: begin
          // Bit 0 is the last step
          if (bit_cnt == '0) begin
            done  <= 1'b1;
            state <= SCALAR_IDLE;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: state <= SCALAR_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == SCALAR_IDLE) begin
      if (mul_start) begin
        op_q   <= operand;
        mult_q <= multiplicand;
        acc    <= '0;
      end
    end else begin
      acc <= sum_red[DATA_SIZE-1:0];
    end
  end

  // Partial result holds the final value while idle
  assign result = acc;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_operand_reduced: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> operand.data < operand.modulo)
    else $error("multiplier operand not below modulus");

  a_start_when_idle: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> state == SCALAR_IDLE)
    else $error("mul_start while multiplier busy");

endmodule

`default_nettype wire

// File: hdl/ntm_ctrl_pkg.sv
// Control encodings only; the scalar state enum leaves one 2-bit code unused and that code decodes to idle
`default_nettype none

package ntm_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////////////////////////////////////////

  // Vector loop states for element and operand control
  typedef enum logic [1:0] {
    VECTOR_IDLE        = 2'd0,
    VECTOR_WAIT_VECTOR = 2'd1,
    VECTOR_WAIT_SCALAR = 2'd2,
    VECTOR_BUSY        = 2'd3
  } ntm_vector_state_e;

  // Scalar product unit and multiplier
  typedef enum logic [1:0] {
    SCALAR_IDLE     = 2'd0,
    SCALAR_LOAD     = 2'd1,
    SCALAR_MULTIPLY = 2'd2
  } ntm_scalar_state_e;

  // Output strobes, one-cycle pulses
  typedef struct packed {
    logic ready;
    logic vector_end;
    logic scalar_valid;
  } ntm_out_flags_t;

endpackage

`default_nettype wire

// File: hdl/ntm_arith_pkg.sv
// Word width is fixed at 16 bits here; every operand must already be below its modulus (>= 2)
`default_nettype none

package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word width
  ////////////////////////////////////////////////////////////////////////////

  // Width of operands, moduli and results
  localparam int DATA_SIZE = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // One operand or result word
  typedef logic [DATA_SIZE-1:0] ntm_data_t;

  // Operand as seen by the arithmetic blocks
  // Modulus travels with every data word
  typedef struct packed {
    ntm_data_t modulo;
    ntm_data_t data;
  } ntm_operand_t;

endpackage

`default_nettype wire
